// ==== design/tcdm_ic_cfg.svh ====
//////////////////////////////////////////////////
// Configuration macros for the TCDM interconnect
// Include this header in every RTL file that needs bus widths,
// port counts or the fixed address map
//////////////////////////////////////////////////

`ifndef TCDM_IC_CFG_SVH
`define TCDM_IC_CFG_SVH

// Bus widths
`define TCDM_ADDR_W      32
`define TCDM_DATA_W      32
`define TCDM_BE_W        4

// Port counts and the slave word-address width
// The bank count must stay a power of two
`define TCDM_NUM_MASTERS 2
`define TCDM_NUM_BANKS   4
`define TCDM_BANK_AW     8

// Fixed address map, byte addresses
`define TCDM_IL_BASE     32'h0000_1000
`define TCDM_IL_SIZE     32'h0000_1000
`define TCDM_CT_BASE     32'h0000_2000
`define TCDM_CT_SIZE     32'h0000_0400

// Word returned by the error responder
`define TCDM_ERR_RDATA   32'hBADA_CCE5

`endif

// ==== design/tcdm_ic_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the TCDM interconnect
// Modules import this package in their body and use scoped names in ports
//////////////////////////////////////////////////

`include "tcdm_ic_cfg.svh"

package tcdm_ic_pkg;

    // Where a decoded master request ends up
    typedef enum logic [1:0] {
        TGT_BANK   = 2'd0,
        TGT_CONTIG = 2'd1,
        TGT_ERROR  = 2'd2
    } tcdm_target_e;

    // Bus payload words
    typedef logic [`TCDM_ADDR_W-1:0] addr_t;
    typedef logic [`TCDM_DATA_W-1:0] data_t;
    typedef logic [`TCDM_BE_W-1:0]   be_t;

    // Word address as seen by a bank or the contiguous slave
    typedef logic [`TCDM_BANK_AW-1:0] local_addr_t;

    // One bit per master, used for request masks and grants
    typedef logic [`TCDM_NUM_MASTERS-1:0] master_vec_t;

    // Bank number taken from the low word-address bits
    typedef logic [$clog2(`TCDM_NUM_BANKS)-1:0] bank_idx_t;

endpackage

// ==== design/tcdm_addr_decoder.sv ====
//////////////////////////////////////////////////
// Address decoder for one TCDM master
// Maps a byte address onto the interleaved banks, the contiguous slave or
// the error responder and forms the slave-local word address
//////////////////////////////////////////////////

`include "tcdm_ic_cfg.svh"

module tcdm_addr_decoder (
    input  tcdm_ic_pkg::addr_t        addr_i,
    output tcdm_ic_pkg::tcdm_target_e target_o,
    output tcdm_ic_pkg::bank_idx_t    bank_o,
    output tcdm_ic_pkg::local_addr_t  local_addr_o
);
    import tcdm_ic_pkg::*;

    // Number of word-address bits used to pick a bank
    localparam int unsigned BankSelW = $bits(bank_idx_t);

    // Offsets of the address into each region
    addr_t il_off;
    addr_t ct_off;
    // Word address before truncation to the slave width
    addr_t word_full;
    logic  in_il;
    logic  in_ct;

    // An unsigned offset below the size covers both region bounds at once
    assign il_off = addr_i - addr_t'(`TCDM_IL_BASE);
    assign ct_off = addr_i - addr_t'(`TCDM_CT_BASE);
    assign in_il  = (il_off < addr_t'(`TCDM_IL_SIZE));
    assign in_ct  = (ct_off < addr_t'(`TCDM_CT_SIZE));

    always_comb begin
        target_o  = TGT_ERROR;
        word_full = '0;
        if (in_il) begin
            target_o  = TGT_BANK;
            // Drop the byte offset and the bank-select bits
            word_full = il_off >> (2 + BankSelW);
        end else if (in_ct) begin
            target_o  = TGT_CONTIG;
            word_full = ct_off >> 2;
        end
    end

    // Consecutive words go to consecutive banks
    assign bank_o       = addr_i[2 +: BankSelW];
    assign local_addr_o = word_full[`TCDM_BANK_AW-1:0];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // The region sizes in the map must fit the slave address width
    always_comb begin
        assert final ((target_o == TGT_ERROR) || ((word_full >> `TCDM_BANK_AW) == '0))
            else $error("Decoded word address 0x%0h exceeds the slave range", word_full);
    end

endmodule

// ==== design/tcdm_slave_arbiter.sv ====
//////////////////////////////////////////////////
// Round-robin arbiter in front of one TCDM slave
// Picks one requesting master and forwards its payload, one instance per slave
//////////////////////////////////////////////////

`include "tcdm_ic_cfg.svh"

module tcdm_slave_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  tcdm_ic_pkg::master_vec_t req_i,
    input  tcdm_ic_pkg::local_addr_t addr_i [`TCDM_NUM_MASTERS],
    input  tcdm_ic_pkg::master_vec_t we_i,
    input  tcdm_ic_pkg::be_t         be_i [`TCDM_NUM_MASTERS],
    input  tcdm_ic_pkg::data_t       wdata_i [`TCDM_NUM_MASTERS],
    input  logic                     slave_gnt_i,
    output logic                     slave_req_o,
    output tcdm_ic_pkg::local_addr_t slave_addr_o,
    output logic                     slave_we_o,
    output tcdm_ic_pkg::be_t         slave_be_o,
    output tcdm_ic_pkg::data_t       slave_wdata_o,
    output tcdm_ic_pkg::master_vec_t grant_o
);
    import tcdm_ic_pkg::*;

    localparam int unsigned NumMasters = `TCDM_NUM_MASTERS;
    localparam int unsigned IdxW       = (NumMasters > 1) ? $clog2(NumMasters) : 1;

    // Master with the highest priority in the current cycle
    logic [IdxW-1:0] ptr_q;
    logic [IdxW-1:0] win_idx;
    logic            win_valid;
    master_vec_t     win_onehot;

    // Walk the masters starting at the pointer and take the first request
    always_comb begin
        int unsigned cand;
        win_idx   = ptr_q;
        win_valid = 1'b0;
        for (int unsigned i = 0; i < NumMasters; i++) begin
            cand = (ptr_q + i) % NumMasters;
            if (!win_valid && req_i[cand]) begin
                win_valid = 1'b1;
                win_idx   = IdxW'(cand);
            end
        end
    end

    // Payload mux towards the slave
    assign slave_req_o   = win_valid;
    assign slave_addr_o  = addr_i[win_idx];
    assign slave_we_o    = we_i[win_idx];
    assign slave_be_o    = be_i[win_idx];
    assign slave_wdata_o = wdata_i[win_idx];

    // A master is only granted when the slave accepts the transfer
    always_comb begin
        win_onehot          = '0;
        win_onehot[win_idx] = win_valid;
    end
    assign grant_o = win_onehot & {NumMasters{slave_gnt_i}};

    // Priority moves one past the winner after each accepted transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (win_valid && slave_gnt_i) begin
            if (win_idx == IdxW'(NumMasters - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= win_idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(grant_o))
        else $error("Slave granted more than one master");

    assert property (@(posedge clk_i) disable iff (!rst_ni) (grant_o & ~req_i) == '0)
        else $error("Grant given to a master without a request");

endmodule

// ==== design/tcdm_master_return.sv ====
//////////////////////////////////////////////////
// Grant and response path back to the TCDM masters
// Merges the slave grants, hosts the error responder and returns each
// response exactly one cycle after its grant
//////////////////////////////////////////////////

`include "tcdm_ic_cfg.svh"

module tcdm_master_return (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  tcdm_ic_pkg::master_vec_t req_i,
    input  tcdm_ic_pkg::master_vec_t err_sel_i,
    input  tcdm_ic_pkg::master_vec_t bank_grant_i [`TCDM_NUM_BANKS],
    input  tcdm_ic_pkg::master_vec_t ct_grant_i,
    input  tcdm_ic_pkg::data_t       bank_rdata_i [`TCDM_NUM_BANKS],
    input  tcdm_ic_pkg::data_t       ct_rdata_i,
    output tcdm_ic_pkg::master_vec_t gnt_o,
    output tcdm_ic_pkg::master_vec_t r_valid_o,
    output tcdm_ic_pkg::data_t       r_rdata_o [`TCDM_NUM_MASTERS],
    output tcdm_ic_pkg::master_vec_t r_opc_o
);
    import tcdm_ic_pkg::*;

    localparam int unsigned NumMasters = `TCDM_NUM_MASTERS;
    localparam int unsigned NumBanks   = `TCDM_NUM_BANKS;

    // The error responder grants any request at once
    master_vec_t  err_gnt;
    master_vec_t  bank_any;
    master_vec_t  valid_q;
    tcdm_target_e src_d [NumMasters];
    tcdm_target_e src_q [NumMasters];
    bank_idx_t    bank_d [NumMasters];
    bank_idx_t    bank_q [NumMasters];

    assign err_gnt = req_i & err_sel_i;
    assign gnt_o   = err_gnt | ct_grant_i | bank_any;

    //////////////////////////////////////////////////
    // Per-master source tracking
    //////////////////////////////////////////////////

    for (genvar m = 0; m < NumMasters; m++) begin : gen_master
        // Grants of all banks for this master
        logic [NumBanks-1:0] bank_hits;

        for (genvar b = 0; b < NumBanks; b++) begin : gen_hit
            assign bank_hits[b] = bank_grant_i[b][m];
        end

        assign bank_any[m] = |bank_hits;

        always_comb begin
            bank_d[m] = '0;
            for (int b = 0; b < NumBanks; b++) begin
                if (bank_hits[b]) begin
                    bank_d[m] = bank_idx_t'(b);
                end
            end
            if (err_gnt[m]) begin
                src_d[m] = TGT_ERROR;
            end else if (ct_grant_i[m]) begin
                src_d[m] = TGT_CONTIG;
            end else begin
                src_d[m] = TGT_BANK;
            end
        end

        // Remember who served the granted request
        always_ff @(posedge clk_i) begin
            if (gnt_o[m]) begin
                src_q[m]  <= src_d[m];
                bank_q[m] <= bank_d[m];
            end
        end

        // Slaves answer in the cycle after the grant, so just pick the source
        always_comb begin
            r_rdata_o[m] = '0;
            if (valid_q[m]) begin
                unique case (src_q[m])
                    TGT_BANK:   r_rdata_o[m] = bank_rdata_i[bank_q[m]];
                    TGT_CONTIG: r_rdata_o[m] = ct_rdata_i;
                    default:    r_rdata_o[m] = `TCDM_ERR_RDATA;
                endcase
            end
        end

        assign r_opc_o[m] = valid_q[m] & (src_q[m] == TGT_ERROR);

        // A request targets one slave, so at most one source may grant it
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            $onehot0({err_gnt[m], ct_grant_i[m], bank_hits}))
            else $error("Master %0d granted by several slaves", m);

        assert property (@(posedge clk_i) disable iff (!rst_ni)
            r_valid_o[m] |-> $past(gnt_o[m]))
            else $error("Response to master %0d without a grant", m);
    end

    // Response valid follows the grant by one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= gnt_o;
        end
    end

    assign r_valid_o = valid_q;

endmodule

// ==== design/tcdm_interconnect.sv ====
//////////////////////////////////////////////////
// TCDM interconnect top level
// Connects the masters to four interleaved banks, one contiguous slave and
// an internal error responder for unmapped addresses
//////////////////////////////////////////////////

`include "tcdm_ic_cfg.svh"

module tcdm_interconnect (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Master ports
    input  tcdm_ic_pkg::master_vec_t req_i,
    input  tcdm_ic_pkg::addr_t       addr_i [`TCDM_NUM_MASTERS],
    input  tcdm_ic_pkg::master_vec_t we_i,
    input  tcdm_ic_pkg::be_t         be_i [`TCDM_NUM_MASTERS],
    input  tcdm_ic_pkg::data_t       wdata_i [`TCDM_NUM_MASTERS],
    output tcdm_ic_pkg::master_vec_t gnt_o,
    output tcdm_ic_pkg::master_vec_t r_valid_o,
    output tcdm_ic_pkg::data_t       r_rdata_o [`TCDM_NUM_MASTERS],
    output tcdm_ic_pkg::master_vec_t r_opc_o,
    // Interleaved bank ports
    output logic [`TCDM_NUM_BANKS-1:0] bank_req_o,
    output tcdm_ic_pkg::local_addr_t   bank_addr_o [`TCDM_NUM_BANKS],
    output logic [`TCDM_NUM_BANKS-1:0] bank_we_o,
    output tcdm_ic_pkg::be_t           bank_be_o [`TCDM_NUM_BANKS],
    output tcdm_ic_pkg::data_t         bank_wdata_o [`TCDM_NUM_BANKS],
    input  logic [`TCDM_NUM_BANKS-1:0] bank_gnt_i,
    input  tcdm_ic_pkg::data_t         bank_rdata_i [`TCDM_NUM_BANKS],
    // Contiguous slave port
    output logic                     ct_req_o,
    output tcdm_ic_pkg::local_addr_t ct_addr_o,
    output logic                     ct_we_o,
    output tcdm_ic_pkg::be_t         ct_be_o,
    output tcdm_ic_pkg::data_t       ct_wdata_o,
    input  logic                     ct_gnt_i,
    input  tcdm_ic_pkg::data_t       ct_rdata_i
);
    import tcdm_ic_pkg::*;

    localparam int unsigned NumMasters = `TCDM_NUM_MASTERS;
    localparam int unsigned NumBanks   = `TCDM_NUM_BANKS;

    // Decoder results per master
    tcdm_target_e target [NumMasters];
    bank_idx_t    bank_sel [NumMasters];
    local_addr_t  local_addr [NumMasters];

    // Request masks and grants per slave
    master_vec_t  bank_grant [NumBanks];
    master_vec_t  ct_mask;
    master_vec_t  ct_grant;
    master_vec_t  err_sel;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    for (genvar m = 0; m < NumMasters; m++) begin : gen_dec
        tcdm_addr_decoder i_dec (
            .addr_i       (addr_i[m]),
            .target_o     (target[m]),
            .bank_o       (bank_sel[m]),
            .local_addr_o (local_addr[m])
        );

        assign ct_mask[m] = req_i[m] & (target[m] == TGT_CONTIG);
        assign err_sel[m] = (target[m] == TGT_ERROR);
    end

    //////////////////////////////////////////////////
    // Slave arbitration
    //////////////////////////////////////////////////

    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
        master_vec_t mask;

        for (genvar m = 0; m < NumMasters; m++) begin : gen_mask
            assign mask[m] = req_i[m] & (target[m] == TGT_BANK) &
                             (bank_sel[m] == bank_idx_t'(b));
        end

        tcdm_slave_arbiter i_arb (
            .clk_i, .rst_ni,
            .req_i (mask), .addr_i (local_addr), .we_i, .be_i, .wdata_i,
            .slave_gnt_i   (bank_gnt_i[b]),
            .slave_req_o   (bank_req_o[b]),
            .slave_addr_o  (bank_addr_o[b]),
            .slave_we_o    (bank_we_o[b]),
            .slave_be_o    (bank_be_o[b]),
            .slave_wdata_o (bank_wdata_o[b]),
            .grant_o       (bank_grant[b])
        );
    end

    tcdm_slave_arbiter i_ct_arb (
        .clk_i, .rst_ni,
        .req_i (ct_mask), .addr_i (local_addr), .we_i, .be_i, .wdata_i,
        .slave_gnt_i (ct_gnt_i), .slave_req_o (ct_req_o), .slave_addr_o (ct_addr_o),
        .slave_we_o  (ct_we_o), .slave_be_o (ct_be_o), .slave_wdata_o (ct_wdata_o),
        .grant_o     (ct_grant)
    );

    // Output side with the grants and the one-cycle-late responses
    tcdm_master_return i_ret (
        .clk_i, .rst_ni, .req_i,
        .err_sel_i    (err_sel),
        .bank_grant_i (bank_grant),
        .ct_grant_i   (ct_grant),
        .bank_rdata_i, .ct_rdata_i,
        .gnt_o, .r_valid_o, .r_rdata_o, .r_opc_o
    );

endmodule

// ==== verification/tb_tcdm_interconnect.sv ====
//////////////////////////////////////////////////
// Self-checking testbench for the TCDM interconnect
// Two random masters, memory models for the four banks and the contiguous
// slave, and a reference image that predicts every response
//////////////////////////////////////////////////

`include "tcdm_ic_cfg.svh"

module tb_tcdm_interconnect;

    localparam int NumM     = `TCDM_NUM_MASTERS;
    localparam int NumB     = `TCDM_NUM_BANKS;
    localparam int NumRand  = 200;
    localparam int NumCont  = 20;
    localparam int MaxCycle = (NumRand + NumCont) * 2 * 4;
    // Slave index NumB stands for the contiguous slave
    localparam int CtIdx    = NumB;
    localparam int Depth    = 1 << `TCDM_BANK_AW;

    logic                     clk_i;
    logic                     rst_ni;
    logic [NumM-1:0]          req_i;
    logic [`TCDM_ADDR_W-1:0]  addr_i [NumM];
    logic [NumM-1:0]          we_i;
    logic [`TCDM_BE_W-1:0]    be_i [NumM];
    logic [`TCDM_DATA_W-1:0]  wdata_i [NumM];
    logic [NumM-1:0]          gnt_o;
    logic [NumM-1:0]          r_valid_o;
    logic [`TCDM_DATA_W-1:0]  r_rdata_o [NumM];
    logic [NumM-1:0]          r_opc_o;
    logic [NumB-1:0]          bank_req_o;
    logic [`TCDM_BANK_AW-1:0] bank_addr_o [NumB];
    logic [NumB-1:0]          bank_we_o;
    logic [`TCDM_BE_W-1:0]    bank_be_o [NumB];
    logic [`TCDM_DATA_W-1:0]  bank_wdata_o [NumB];
    logic [NumB-1:0]          bank_gnt_i;
    logic [`TCDM_DATA_W-1:0]  bank_rdata_i [NumB];
    logic                     ct_req_o;
    logic [`TCDM_BANK_AW-1:0] ct_addr_o;
    logic                     ct_we_o;
    logic [`TCDM_BE_W-1:0]    ct_be_o;
    logic [`TCDM_DATA_W-1:0]  ct_wdata_o;
    logic                     ct_gnt_i;
    logic [`TCDM_DATA_W-1:0]  ct_rdata_i;

    integer seed = 19;
    int     errors = 0;
    int     cycle_cnt = 0;

    // Slave memories and the transfer each slave accepted in the last cycle
    logic [31:0] slave_mem [NumB+1][Depth];
    logic        pend_vld [NumB+1];
    logic        pend_we [NumB+1];
    logic [7:0]  pend_addr [NumB+1];
    logic [3:0]  pend_be [NumB+1];
    logic [31:0] pend_wdata [NumB+1];

    // Reference image by word address, round-robin pointers and expected responses
    logic [31:0] ref_img [logic [31:0]];
    int          rr_ptr [NumB+1];
    logic        exp_vld [NumM];
    logic        exp_opc [NumM];
    logic [31:0] exp_rdata [NumM];
    logic        granted [NumM];

    tcdm_interconnect dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Address map and data helpers
    //////////////////////////////////////////////////

    // Target code of a byte address is 0 for the banks, 1 for the contiguous slave
    // and 2 when unmapped
    function automatic int target_of(input logic [31:0] a);
        if (a >= `TCDM_IL_BASE && a < `TCDM_IL_BASE + `TCDM_IL_SIZE) return 0;
        if (a >= `TCDM_CT_BASE && a < `TCDM_CT_BASE + `TCDM_CT_SIZE) return 1;
        return 2;
    endfunction

    function automatic int slave_of(input logic [31:0] a);
        return (target_of(a) == 0) ? int'(a[3:2]) : CtIdx;
    endfunction

    function automatic logic [7:0] local_of(input logic [31:0] a);
        if (target_of(a) == 0) return 8'(a >> 4);
        return 8'((a - `TCDM_CT_BASE) >> 2);
    endfunction

    // Master m has a pending request for slave s
    function automatic logic wants(input int m, input int s);
        return req_i[m] && (target_of(addr_i[m]) != 2) && (slave_of(addr_i[m]) == s);
    endfunction

    // Initial memory content that differs for every byte address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic [31:0] apply_be(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        if (ref_img.exists(a >> 2)) return ref_img[a >> 2];
        return fill_word({a[31:2], 2'b00});
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Slave models and masters
    //////////////////////////////////////////////////

    task automatic read_slave_port(input int s, output logic req, output logic gnt,
                                   output logic [7:0] addr, output logic we,
                                   output logic [3:0] be, output logic [31:0] wdata);
        if (s == CtIdx) begin
            req   = ct_req_o;
            gnt   = ct_gnt_i;
            addr  = ct_addr_o;
            we    = ct_we_o;
            be    = ct_be_o;
            wdata = ct_wdata_o;
        end else begin
            req   = bank_req_o[s];
            gnt   = bank_gnt_i[s];
            addr  = bank_addr_o[s];
            we    = bank_we_o[s];
            be    = bank_be_o[s];
            wdata = bank_wdata_o[s];
        end
    endtask

    // Answers last cycle's transfer and draws a new gnt that is high 70% of the time
    // unless forced
    task automatic serve_slaves(input bit full_gnt);
        logic [31:0] rdata;
        logic        gnt;
        for (int s = 0; s <= NumB; s++) begin
            // Idle slaves drive noise so that a wrong return mux shows up
            rdata = $random(seed);
            if (pend_vld[s]) begin
                if (pend_we[s]) begin
                    slave_mem[s][pend_addr[s]] =
                        apply_be(slave_mem[s][pend_addr[s]], pend_wdata[s], pend_be[s]);
                    rdata = '0;
                end else begin
                    rdata = slave_mem[s][pend_addr[s]];
                end
            end
            gnt = full_gnt || ((($random(seed) & 32'h7fff_ffff) % 100) < 70);
            if (s == CtIdx) begin
                ct_gnt_i   = gnt;
                ct_rdata_i = rdata;
            end else begin
                bank_gnt_i[s]   = gnt;
                bank_rdata_i[s] = rdata;
            end
        end
    endtask

    // In contention mode every request goes to bank 0
    task automatic new_request(input int m, input bit contend);
        logic [31:0] r;
        logic [31:0] a;
        int          kind;
        r    = $random(seed);
        kind = contend ? 0 : (($random(seed) & 32'h7fff_ffff) % 3);
        case (kind)
            // Bit 31 of r picks a narrow window that makes reads hit earlier writes
            0: a = `TCDM_IL_BASE + (contend ? ((r & 32'h3F) << 4) :
                                              (r & (r[31] ? 32'hFFC : 32'hFC)));
            1: a = `TCDM_CT_BASE + (r & (r[31] ? 32'h3FC : 32'h7C));
            default: begin
                a = r & 32'hFFFF_FFFC;
                if (target_of(a) != 2) a[31] = 1'b1;
            end
        endcase
        req_i[m]   = 1'b1;
        addr_i[m]  = a;
        we_i[m]    = $random(seed);
        be_i[m]    = $random(seed);
        wdata_i[m] = $random(seed);
    endtask

    //////////////////////////////////////////////////
    // Per-cycle checks at the falling edge
    //////////////////////////////////////////////////

    task automatic check_cycle();
        logic        s_req;
        logic        s_gnt;
        logic [7:0]  s_addr;
        logic        s_we;
        logic [3:0]  s_be;
        logic [31:0] s_wdata;
        logic        hit;
        string       pfx;
        int          win;
        int          m;
        logic [31:0] a;
        logic        model_gnt [NumM];
        // Responses owed for the grants of the previous cycle
        for (int k = 0; k < NumM; k++) begin
            check_value("r_valid_o", exp_vld[k], r_valid_o[k]);
            if (exp_vld[k]) begin
                check_value("r_opc_o", exp_opc[k], r_opc_o[k]);
                check_value("r_rdata_o", exp_rdata[k], r_rdata_o[k]);
            end
            model_gnt[k] = 1'b0;
        end
        // Slave request, round-robin winner and forwarded payload
        for (int s = 0; s <= NumB; s++) begin
            read_slave_port(s, s_req, s_gnt, s_addr, s_we, s_be, s_wdata);
            pfx = (s == CtIdx) ? "ct" : $sformatf("bank%0d", s);
            hit = 1'b0;
            win = -1;
            for (int i = 0; i < NumM; i++) begin
                m = (rr_ptr[s] + i) % NumM;
                if (wants(m, s)) begin
                    hit = 1'b1;
                    if (win < 0) win = m;
                end
            end
            check_value({pfx, "_req_o"}, hit, s_req);
            for (int k = 0; k < NumM; k++) begin
                if (wants(k, s)) model_gnt[k] = (k == win) && s_gnt;
            end
            pend_vld[s] = hit && s_gnt;
            if (hit && s_gnt) begin
                check_value({pfx, "_addr_o"}, local_of(addr_i[win]), s_addr);
                check_value({pfx, "_we_o"}, we_i[win], s_we);
                check_value({pfx, "_be_o"}, be_i[win], s_be);
                check_value({pfx, "_wdata_o"}, wdata_i[win], s_wdata);
                rr_ptr[s]     = (win + 1) % NumM;
                pend_we[s]    = s_we;
                pend_addr[s]  = s_addr;
                pend_be[s]    = s_be;
                pend_wdata[s] = s_wdata;
            end
        end
        // Predicted grant of each master and the response it promises
        for (int k = 0; k < NumM; k++) begin
            a = addr_i[k];
            // The error responder grants every unmapped request at once
            if (req_i[k] && target_of(a) == 2) model_gnt[k] = 1'b1;
            check_value("gnt_o", model_gnt[k], gnt_o[k]);
            granted[k]   = model_gnt[k];
            exp_vld[k]   = model_gnt[k];
            exp_opc[k]   = 1'b0;
            exp_rdata[k] = '0;
            if (granted[k]) begin
                if (target_of(a) == 2) begin
                    exp_opc[k]   = 1'b1;
                    exp_rdata[k] = `TCDM_ERR_RDATA;
                end else if (we_i[k]) begin
                    ref_img[a >> 2] = apply_be(ref_read(a), wdata_i[k], be_i[k]);
                end else begin
                    exp_rdata[k] = ref_read(a);
                end
            end
        end
    endtask

    // Each master issues n requests and holds each one until its grant
    task automatic run_phase(input int n, input bit contend);
        int   issued [NumM];
        logic busy;
        foreach (issued[k]) issued[k] = 0;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk_i);
            #1;
            serve_slaves(contend);
            busy = 1'b0;
            for (int k = 0; k < NumM; k++) begin
                if (!req_i[k] || granted[k]) begin
                    if (issued[k] < n) begin
                        new_request(k, contend);
                        issued[k]++;
                    end else begin
                        req_i[k] = 1'b0;
                    end
                end
                if (req_i[k]) busy = 1'b1;
            end
            @(negedge clk_i);
            check_cycle();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
            serve_slaves(1'b0);
            req_i = '0;
            @(negedge clk_i);
            check_cycle();
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence and timeout
    //////////////////////////////////////////////////

    initial begin
        rst_ni     = 1'b0;
        req_i      = '0;
        we_i       = '0;
        bank_gnt_i = '1;
        ct_gnt_i   = 1'b1;
        ct_rdata_i = '0;
        for (int k = 0; k < NumM; k++) begin
            addr_i[k]  = '0;
            be_i[k]    = '0;
            wdata_i[k] = '0;
            exp_vld[k] = 1'b0;
            granted[k] = 1'b0;
        end
        for (int s = 0; s <= NumB; s++) begin
            if (s < NumB) bank_rdata_i[s] = '0;
            pend_vld[s] = 1'b0;
            rr_ptr[s]   = 0;
            for (int i = 0; i < Depth; i++) begin
                slave_mem[s][i] = (s == CtIdx) ? fill_word(`TCDM_CT_BASE + (i << 2)) :
                                  fill_word(`TCDM_IL_BASE + (i << 4) + (s << 2));
            end
        end
        // Slave gnts stay high in reset while nothing may reach the masters or slaves
        repeat (16) begin
            @(negedge clk_i);
            check_value("gnt_o", '0, gnt_o);
            check_value("r_valid_o", '0, r_valid_o);
            check_value("bank_req_o", '0, bank_req_o);
            check_value("ct_req_o", 1'b0, ct_req_o);
        end
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        idle_cycles(3);
        run_phase(NumRand, 1'b0);
        run_phase(NumCont, 1'b1);
        idle_cycles(3);
        $display("Checks complete, error count: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < MaxCycle) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, some request was never granted", cycle_cnt);
        $display("Error count before the timeout: %0d", errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/tcdm_ic_pkg.sv
design/tcdm_addr_decoder.sv
design/tcdm_slave_arbiter.sv
design/tcdm_master_return.sv
design/tcdm_interconnect.sv
verification/tb_tcdm_interconnect.sv

// ==== Bender.yml ====
package:
  name: tcdm_interconnect

sources:
  - include_dirs:
      - design
    files:
      - design/tcdm_ic_pkg.sv
      - design/tcdm_addr_decoder.sv
      - design/tcdm_slave_arbiter.sv
      - design/tcdm_master_return.sv
      - design/tcdm_interconnect.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tb_tcdm_interconnect.sv
